// File: rtl/screen_pkg.sv
package screen_pkg;

    // Raster coordinates
    typedef logic [10:0] px_x_t;
    typedef logic [9:0]  px_y_t;

    // Colors
    typedef logic [3:0]  chan_t;
    typedef logic [11:0] rgb12_t;

    // Sprite ROM addresses one 16x16 tile, 2x2 pixels per entry
    typedef logic [3:0]  sprite_coord_t;

    // =========================================================================
    // Layout
    // =========================================================================
    localparam int block_size   = 32;
    localparam int border_width = 4;

    // Preview box, to the right of the field
    localparam int next_gap      = 50;
    localparam int next_box      = 150;
    localparam int next_header_h = 20;
    localparam int next_pad_x    = 20;
    localparam int next_pad_y    = 40;

    // =========================================================================
    // Fixed colors
    // =========================================================================
    localparam rgb12_t border_color = 12'hCCC;
    localparam rgb12_t line_color   = 12'h333;
    localparam rgb12_t ghost_color  = 12'h555;
    localparam rgb12_t dead_color   = 12'h444;
    localparam rgb12_t header_color = 12'hFFF;

endpackage

// File: rtl/tetris_pkg.sv
package tetris_pkg;

    // Playfield geometry, counted in cells
    localparam int field_cols  = 10;
    localparam int field_rows  = 22;
    localparam int hidden_rows = 2;

    // Tetromino kinds
    typedef logic [2:0] piece_kind_t;

    localparam piece_kind_t piece_i     = 3'd0;
    localparam piece_kind_t piece_j     = 3'd1;
    localparam piece_kind_t piece_l     = 3'd2;
    localparam piece_kind_t piece_o     = 3'd3;
    localparam piece_kind_t piece_s     = 3'd4;
    localparam piece_kind_t piece_t     = 3'd5;
    localparam piece_kind_t piece_z     = 3'd6;
    localparam piece_kind_t piece_empty = 3'd7;

    // 4x4 mask, row-major, bit 0 is row 0 column 0
    typedef logic [15:0] piece_shape_t;

    // Row 0 at the low end, column 0 lowest within a row
    typedef logic [field_rows*field_cols*$bits(piece_kind_t)-1:0] field_vec_t;

    // Palette index: 0 is nothing, else kind plus 1
    typedef logic [3:0] color_idx_t;

    // Palette, red in the top nibble
    function automatic logic [11:0] kind_color(color_idx_t idx);
        case (idx)
            4'd1:    return 12'h0FF;
            4'd2:    return 12'h00F;
            4'd3:    return 12'hF80;
            4'd4:    return 12'hFF0;
            4'd5:    return 12'h0F0;
            4'd6:    return 12'hF0F;
            4'd7:    return 12'hF00;
            default: return 12'h000;
        endcase
    endfunction

endpackage

// File: rtl/render_if.sv
`timescale 1ns/1ps

// Stage 1 to stage 2: position already classified into regions
interface region_if import screen_pkg::*; ();
    logic       active;
    logic       hsync;
    logic       vsync;
    logic       is_grid;
    logic       is_border;
    logic       is_next;
    logic [3:0] grid_col;
    logic [4:0] grid_row;
    logic [4:0] block_px_x;
    logic [4:0] block_px_y;
    px_x_t      next_rel_x;
    px_y_t      next_rel_y;

    modport producer (
        output active, hsync, vsync, is_grid, is_border, is_next,
               grid_col, grid_row, block_px_x, block_px_y, next_rel_x, next_rel_y
    );
    modport consumer (
        input  active, hsync, vsync, is_grid, is_border, is_next,
               grid_col, grid_row, block_px_x, block_px_y, next_rel_x, next_rel_y
    );
endinterface

// Stage 2 to stage 3: cell content resolved, color still an index
interface cell_if import screen_pkg::*; import tetris_pkg::*; ();
    logic       active;
    logic       hsync;
    logic       vsync;
    logic       is_border;
    logic       is_grid;
    logic       is_next;
    logic       is_grid_line;
    logic       is_ghost;
    logic       next_header;
    color_idx_t cell_color;

    modport producer (
        output active, hsync, vsync, is_border, is_grid, is_next,
               is_grid_line, is_ghost, next_header, cell_color
    );
    modport consumer (
        input  active, hsync, vsync, is_border, is_grid, is_next,
               is_grid_line, is_ghost, next_header, cell_color
    );
endinterface

// File: rtl/screen_region_decoder.sv
`timescale 1ns/1ps

module screen_region_decoder
    import screen_pkg::*;
    import tetris_pkg::*;
#(
    parameter int grid_x0 = 480,
    parameter int grid_y0 = 80
) (
    input  logic       clk,
    input  logic       rst_n,
    input  px_x_t      pix_x,
    input  px_y_t      pix_y,
    input  logic       active,
    input  logic       hsync,
    input  logic       vsync,
    region_if.producer region
);

    localparam int grid_w  = field_cols * block_size;
    localparam int grid_h  = (field_rows - hidden_rows) * block_size;
    localparam int next_x0 = grid_x0 + grid_w + next_gap;
    localparam int next_y0 = grid_y0;

    px_x_t rel_x;
    px_y_t rel_y;
    logic  in_grid;
    logic  in_frame;
    logic  in_ring;
    logic  in_next;

    // Offsets from the field origin wrap when left of or above it
    assign rel_x = pix_x - px_x_t'(grid_x0);
    assign rel_y = pix_y - px_y_t'(grid_y0);

    assign in_grid = pix_x >= grid_x0 && pix_x < grid_x0 + grid_w &&
                     pix_y >= grid_y0 && pix_y < grid_y0 + grid_h;

    // Field plus the ring around it
    assign in_frame = pix_x >= grid_x0 - border_width &&
                      pix_x <  grid_x0 + grid_w + border_width &&
                      pix_y >= grid_y0 - border_width &&
                      pix_y <  grid_y0 + grid_h + border_width;

    // Bands of border_width pixels on each side of the field
    assign in_ring = in_frame && (pix_x < grid_x0 || pix_x >= grid_x0 + grid_w ||
                                  pix_y < grid_y0 || pix_y >= grid_y0 + grid_h);

    assign in_next = pix_x >= next_x0 && pix_x < next_x0 + next_box &&
                     pix_y >= next_y0 && pix_y < next_y0 + next_box;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            region.active    <= 1'b0;
            region.hsync     <= 1'b0;
            region.vsync     <= 1'b0;
            region.is_grid   <= 1'b0;
            region.is_border <= 1'b0;
            region.is_next   <= 1'b0;
        end else begin
            region.active    <= active;
            region.hsync     <= hsync;
            region.vsync     <= vsync;
            region.is_grid   <= in_grid;
            region.is_border <= in_ring;
            region.is_next   <= in_next;
        end
    end

    // Coordinates only mean something where the matching flag is set
    always_ff @(posedge clk) begin
        region.grid_col   <= 4'(rel_x / block_size);
        region.grid_row   <= 5'(rel_y / block_size);
        region.block_px_x <= 5'(rel_x % block_size);
        region.block_px_y <= 5'(rel_y % block_size);
        region.next_rel_x <= pix_x - px_x_t'(next_x0);
        region.next_rel_y <= pix_y - px_y_t'(next_y0);
    end

    a_grid_border_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(region.is_grid && region.is_border));

endmodule

// File: rtl/cell_lookup.sv
`timescale 1ns/1ps

module cell_lookup
    import screen_pkg::*;
    import tetris_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    region_if.consumer    region,
    input  field_vec_t    field,
    input  logic          game_over,
    input  piece_shape_t  curr_shape,
    input  logic [3:0]    curr_col,
    input  logic [4:0]    ghost_row,
    input  piece_shape_t  next_shape,
    input  piece_kind_t   next_kind,
    output sprite_coord_t sprite_addr_x,
    output sprite_coord_t sprite_addr_y,
    cell_if.producer      cells
);

    localparam int kind_w  = $bits(piece_kind_t);
    localparam int piece_w = 4 * block_size;

    logic [4:0]  field_row;
    piece_kind_t cell_kind;
    logic        cell_filled;
    logic [4:0]  ghost_dr;
    logic [4:0]  ghost_dc;
    logic        ghost_hit;
    logic        on_line;
    px_x_t       nx;
    px_y_t       ny;
    logic [1:0]  nr;
    logic [1:0]  nc;
    logic        preview_hit;

    // =========================================================================
    // Playfield and ghost
    // =========================================================================

    // Visible row 0 is field row 2
    assign field_row   = region.grid_row + 5'(hidden_rows);
    assign cell_kind   = field[(int'(field_row) * field_cols + int'(region.grid_col)) * kind_w
                               +: kind_w];
    assign cell_filled = cell_kind != piece_empty;

    // Offset into the piece mask, wraps out of range when left of or above it
    assign ghost_dr = field_row - ghost_row;
    assign ghost_dc = {1'b0, region.grid_col} - {1'b0, curr_col};

    assign ghost_hit = !game_over && !cell_filled && ghost_dr < 5'd4 && ghost_dc < 5'd4 &&
                       curr_shape[{ghost_dr[1:0], ghost_dc[1:0]}];

    assign on_line = region.block_px_x == 5'd0 || region.block_px_x == 5'd31 ||
                     region.block_px_y == 5'd0 || region.block_px_y == 5'd31;

    // =========================================================================
    // Preview box
    // =========================================================================

    // Header rows wrap ny past the piece area, so they never hit a block
    assign nx = region.next_rel_x - px_x_t'(next_pad_x);
    assign ny = region.next_rel_y - px_y_t'(next_pad_y);
    assign nr = 2'(ny / block_size);
    assign nc = 2'(nx / block_size);

    assign preview_hit = nx < piece_w && ny < piece_w && next_shape[{nr, nc}];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cells.active       <= 1'b0;
            cells.hsync        <= 1'b0;
            cells.vsync        <= 1'b0;
            cells.is_border    <= 1'b0;
            cells.is_grid      <= 1'b0;
            cells.is_next      <= 1'b0;
            cells.is_grid_line <= 1'b0;
            cells.is_ghost     <= 1'b0;
            cells.next_header  <= 1'b0;
        end else begin
            cells.active       <= region.active;
            cells.hsync        <= region.hsync;
            cells.vsync        <= region.vsync;
            cells.is_border    <= region.is_border;
            cells.is_grid      <= region.is_grid;
            cells.is_next      <= region.is_next;
            cells.is_grid_line <= region.is_grid && on_line;
            cells.is_ghost     <= region.is_grid && ghost_hit;
            cells.next_header  <= region.is_next && region.next_rel_y < next_header_h;
        end
    end

    // Color index and sprite address, 0 unless a block is drawn here
    always_ff @(posedge clk) begin
        cells.cell_color <= '0;
        sprite_addr_x    <= '0;
        sprite_addr_y    <= '0;
        if (region.is_grid && (cell_filled || ghost_hit)) begin
            if (cell_filled) begin
                cells.cell_color <= color_idx_t'(cell_kind) + 4'd1;
            end
            sprite_addr_x <= region.block_px_x[4:1];
            sprite_addr_y <= region.block_px_y[4:1];
        end else if (region.is_next && preview_hit) begin
            cells.cell_color <= color_idx_t'(next_kind) + 4'd1;
            sprite_addr_x    <= nx[4:1];
            sprite_addr_y    <= ny[4:1];
        end
    end

    a_grid_in_field: assert property (@(posedge clk) disable iff (!rst_n)
        region.is_grid |-> (region.grid_row < field_rows - hidden_rows &&
                            region.grid_col < field_cols));

endmodule

// File: rtl/pixel_colorizer.sv
`timescale 1ns/1ps

module pixel_colorizer
    import screen_pkg::*;
    import tetris_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    cell_if.consumer    cells,
    input  logic        game_over,
    input  logic [11:0] sprite_pixel,
    output chan_t       red,
    output chan_t       green,
    output chan_t       blue,
    output logic        hsync_out,
    output logic        vsync_out
);

    // =========================================================================
    // Stage 3: wait one cycle for the sprite ROM
    // =========================================================================
    logic       a_active;
    logic       a_hsync;
    logic       a_vsync;
    logic       a_is_border;
    logic       a_is_grid;
    logic       a_is_next;
    logic       a_is_grid_line;
    logic       a_is_ghost;
    logic       a_next_header;
    color_idx_t a_cell_color;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_active       <= 1'b0;
            a_hsync        <= 1'b0;
            a_vsync        <= 1'b0;
            a_is_border    <= 1'b0;
            a_is_grid      <= 1'b0;
            a_is_next      <= 1'b0;
            a_is_grid_line <= 1'b0;
            a_is_ghost     <= 1'b0;
            a_next_header  <= 1'b0;
        end else begin
            a_active       <= cells.active;
            a_hsync        <= cells.hsync;
            a_vsync        <= cells.vsync;
            a_is_border    <= cells.is_border;
            a_is_grid      <= cells.is_grid;
            a_is_next      <= cells.is_next;
            a_is_grid_line <= cells.is_grid_line;
            a_is_ghost     <= cells.is_ghost;
            a_next_header  <= cells.next_header;
        end
    end

    always_ff @(posedge clk) begin
        a_cell_color <= cells.cell_color;
    end

    // =========================================================================
    // Stage 4: color mapping
    // =========================================================================
    rgb12_t block_base;
    rgb12_t block_rgb;
    rgb12_t pix;

    always_comb begin
        if (a_is_ghost) begin
            block_base = ghost_color;
        end else if (game_over && a_is_grid) begin
            block_base = dead_color;
        end else begin
            block_base = kind_color(a_cell_color);
        end

        // Sprite edge: every channel at half brightness
        if (sprite_pixel[7:4] != 4'hF) begin
            block_rgb = {1'b0, block_base[11:9], 1'b0, block_base[7:5], 1'b0, block_base[3:1]};
        end else begin
            block_rgb = block_base;
        end

        if (!a_active) begin
            pix = '0;
        end else if (a_is_border) begin
            pix = border_color;
        end else if (a_is_grid_line) begin
            pix = line_color;
        end else if (a_is_grid && (a_cell_color != '0 || a_is_ghost)) begin
            pix = block_rgb;
        end else if (a_next_header) begin
            pix = header_color;
        end else if (a_is_next && a_cell_color != '0) begin
            pix = block_rgb;
        end else begin
            pix = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red       <= '0;
            green     <= '0;
            blue      <= '0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
        end else begin
            red       <= pix[11:8];
            green     <= pix[7:4];
            blue      <= pix[3:0];
            hsync_out <= a_hsync;
            vsync_out <= a_vsync;
        end
    end

    a_black_when_inactive: assert property (@(posedge clk) disable iff (!rst_n)
        !a_active |=> (red == '0 && green == '0 && blue == '0));

endmodule

// File: rtl/tetris_render_top.sv
`timescale 1ns/1ps

module tetris_render_top
    import screen_pkg::*;
    import tetris_pkg::*;
#(
    parameter int grid_x0 = 480,
    parameter int grid_y0 = 80
) (
    input  logic          clk,
    input  logic          rst_n,
    // Raster position
    input  px_x_t         pix_x,
    input  px_y_t         pix_y,
    input  logic          active,
    input  logic          hsync,
    input  logic          vsync,
    // Game state
    input  field_vec_t    field,
    input  logic          game_over,
    input  piece_shape_t  curr_shape,
    input  logic [3:0]    curr_col,
    input  logic [4:0]    ghost_row,
    input  piece_shape_t  next_shape,
    input  piece_kind_t   next_kind,
    // Sprite ROM
    output sprite_coord_t sprite_addr_x,
    output sprite_coord_t sprite_addr_y,
    input  logic [11:0]   sprite_pixel,
    // Video out
    output chan_t         red,
    output chan_t         green,
    output chan_t         blue,
    output logic          hsync_out,
    output logic          vsync_out
);

    region_if region_bus ();
    cell_if   cell_bus ();

    screen_region_decoder #(
        .grid_x0 (grid_x0),
        .grid_y0 (grid_y0)
    ) u_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .pix_x  (pix_x),
        .pix_y  (pix_y),
        .active (active),
        .hsync  (hsync),
        .vsync  (vsync),
        .region (region_bus.producer)
    );

    cell_lookup u_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .region        (region_bus.consumer),
        .field         (field),
        .game_over     (game_over),
        .curr_shape    (curr_shape),
        .curr_col      (curr_col),
        .ghost_row     (ghost_row),
        .next_shape    (next_shape),
        .next_kind     (next_kind),
        .sprite_addr_x (sprite_addr_x),
        .sprite_addr_y (sprite_addr_y),
        .cells         (cell_bus.producer)
    );

    pixel_colorizer u_colorizer (
        .clk          (clk),
        .rst_n        (rst_n),
        .cells        (cell_bus.consumer),
        .game_over    (game_over),
        .sprite_pixel (sprite_pixel),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out)
    );

endmodule

// File: verif/tb_tetris_render.sv
`timescale 1ns/1ps

module tb_tetris_render
    import screen_pkg::*;
    import tetris_pkg::*;
();

    localparam int    half_period    = 20;
    localparam int    reset_cycles   = 10;
    localparam int    latency        = 4;
    localparam int    drive_delay    = 2;
    localparam int    timeout_margin = 20;
    localparam int    kind_w         = $bits(piece_kind_t);
    localparam string input_file     = "verif/tb_render_input.txt";

    // One expected output pixel, due at a given cycle count
    typedef struct packed {
        int    due;
        int    line_no;
        chan_t red;
        chan_t green;
        chan_t blue;
        logic  hsync;
        logic  vsync;
    } expect_t;

    logic          clk = 1'b0;
    logic          rst_n;
    px_x_t         pix_x;
    px_y_t         pix_y;
    logic          active;
    logic          hsync;
    logic          vsync;
    field_vec_t    field;
    logic          game_over;
    piece_shape_t  curr_shape;
    logic [3:0]    curr_col;
    logic [4:0]    ghost_row;
    piece_shape_t  next_shape;
    piece_kind_t   next_kind;
    sprite_coord_t sprite_addr_x;
    sprite_coord_t sprite_addr_y;
    logic [11:0]   sprite_pixel = 12'h000;
    chan_t         red;
    chan_t         green;
    chan_t         blue;
    logic          hsync_out;
    logic          vsync_out;

    expect_t expect_q[$];
    int      cycle_count   = 0;
    int      timeout_limit = 0;
    int      error_count   = 0;
    int      check_count   = 0;

    tetris_render_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_x         (pix_x),
        .pix_y         (pix_y),
        .active        (active),
        .hsync         (hsync),
        .vsync         (vsync),
        .field         (field),
        .game_over     (game_over),
        .curr_shape    (curr_shape),
        .curr_col      (curr_col),
        .ghost_row     (ghost_row),
        .next_shape    (next_shape),
        .next_kind     (next_kind),
        .sprite_addr_x (sprite_addr_x),
        .sprite_addr_y (sprite_addr_y),
        .sprite_pixel  (sprite_pixel),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .hsync_out     (hsync_out),
        .vsync_out     (vsync_out)
    );

    always #half_period clk = ~clk;

    // Sprite ROM model: dim rim along the top and left of each tile
    always @(posedge clk) begin
        if (sprite_addr_x == '0 || sprite_addr_y == '0) begin
            sprite_pixel <= 12'h080;
        end else begin
            sprite_pixel <= 12'h0F0;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_rgb(string name, int line_no, chan_t exp_val, chan_t act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("** Error %s: expected 0x%h, got 0x%h (input line %0d)",
                     name, exp_val, act_val, line_no);
        end
    endtask

    task automatic check_sync(string name, int line_no, logic exp_val, logic act_val);
        check_count++;
        if (act_val !== exp_val) begin
            error_count++;
            $display("** Error %s: expected 0x%h, got 0x%h (input line %0d)",
                     name, exp_val, act_val, line_no);
        end
    endtask

    // Line 0 stands for an idle pixel, black with both syncs low
    task automatic check_outputs();
        expect_t e;
        e = '0;
        if (expect_q.size() > 0 && expect_q[0].due == cycle_count) begin
            e = expect_q.pop_front();
        end
        check_rgb("red", e.line_no, e.red, red);
        check_rgb("green", e.line_no, e.green, green);
        check_rgb("blue", e.line_no, e.blue, blue);
        check_sync("hsync_out", e.line_no, e.hsync, hsync_out);
        check_sync("vsync_out", e.line_no, e.vsync, vsync_out);
    endtask

    // ========================================================================
    // Stimulus helpers
    // ========================================================================
    task automatic step_cycle();
        @(posedge clk);
        #drive_delay;
        check_outputs();
    endtask

    task automatic drive_idle();
        pix_x  = '0;
        pix_y  = '0;
        active = 1'b0;
        hsync  = 1'b0;
        vsync  = 1'b0;
    endtask

    // Game state may only change with no probe in flight
    task automatic drain_pipeline();
        while (expect_q.size() > 0) begin
            drive_idle();
            step_cycle();
        end
    endtask

    // Leftmost hex digit is column 0
    task automatic load_field_row(int row, logic [39:0] digits);
        int c;
        for (c = 0; c < field_cols; c++) begin
            field[(row * field_cols + c) * kind_w +: kind_w] =
                digits[(field_cols - 1 - c) * 4 +: kind_w];
        end
    endtask

    task automatic count_lines(output int n_probes, output int n_setup);
        int    fd;
        string line;
        n_probes = 0;
        n_setup  = 0;
        fd = $fopen(input_file, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.getc(0) == "P") begin
                    n_probes++;
                end else if (line.getc(0) == "F" || line.getc(0) == "C") begin
                    n_setup++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int          fd;
        int          n_probes;
        int          n_setup;
        int          line_no;
        int          n;
        int          v [0:9];
        string       line;
        byte         tag;
        logic [39:0] digits;
        expect_t     e;

        rst_n      = 1'b0;
        field      = '1;
        game_over  = 1'b0;
        curr_shape = '0;
        curr_col   = '0;
        ghost_row  = '0;
        next_shape = '0;
        next_kind  = piece_empty;
        drive_idle();

        // Every F or C line may cost one drain of the pipeline
        count_lines(n_probes, n_setup);
        timeout_limit = reset_cycles + n_probes + (n_setup + 1) * latency + timeout_margin;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        fd = $fopen(input_file, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", input_file);
            error_count++;
        end else begin
            line_no = 0;
            while ($fgets(line, fd) > 0) begin
                line_no++;
                tag = line.getc(0);
                if (tag == "F") begin
                    n = $sscanf(line, "F %d %h", v[0], digits);
                    if (n != 2) begin
                        $display("Malformed field line %0d in the stimulus file", line_no);
                        error_count++;
                    end else begin
                        drain_pipeline();
                        load_field_row(v[0], digits);
                    end
                end else if (tag == "C") begin
                    n = $sscanf(line, "C %d %h %d %d %h %d", v[0], v[1], v[2], v[3], v[4], v[5]);
                    if (n != 6) begin
                        $display("Malformed piece line %0d in the stimulus file", line_no);
                        error_count++;
                    end else begin
                        drain_pipeline();
                        game_over  = v[0][0];
                        curr_shape = piece_shape_t'(v[1]);
                        curr_col   = 4'(v[2]);
                        ghost_row  = 5'(v[3]);
                        next_shape = piece_shape_t'(v[4]);
                        next_kind  = piece_kind_t'(v[5]);
                    end
                end else if (tag == "P") begin
                    n = $sscanf(line, "P %d %d %d %d %d %h %h %h %d %d", v[0], v[1], v[2],
                                v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (n != 10) begin
                        $display("Malformed probe line %0d in the stimulus file", line_no);
                        error_count++;
                    end else begin
                        pix_x     = px_x_t'(v[0]);
                        pix_y     = px_y_t'(v[1]);
                        active    = v[2][0];
                        hsync     = v[3][0];
                        vsync     = v[4][0];
                        e.due     = cycle_count + latency;
                        e.line_no = line_no;
                        e.red     = chan_t'(v[5]);
                        e.green   = chan_t'(v[6]);
                        e.blue    = chan_t'(v[7]);
                        e.hsync   = v[8][0];
                        e.vsync   = v[9][0];
                        expect_q.push_back(e);
                        step_cycle();
                    end
                end
            end
            $fclose(fd);
            drain_pipeline();
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verif/tb_render_input.txt
# F row kinds: field row 0 to 21, ten kind digits from column 0, digit 7 is empty
# C game_over curr_shape curr_col ghost_row next_shape next_kind (shapes in hex)
# P x y active hsync vsync, then expected red green blue (hex) hsync vsync
F 1 0000000000
F 2 5777777777
F 21 0123456777
C 0 0027 3 18 0066 3
# Syncs and pixels outside the field
P 100 100 0 1 0  0 0 0 1 0
P 102 100 1 1 1  0 0 0 1 1
# Border ring and grid lines
P 476 300 1 0 1  C C C 0 1
P 803 723 1 0 0  C C C 0 0
P 476 300 0 0 0  0 0 0 0 0
P 804 300 1 0 0  0 0 0 0 0
P 480 300 1 0 0  3 3 3 0 0
P 511 300 0 0 0  0 0 0 0 0
P 480 700 1 0 0  3 3 3 0 0
# Filled cells, full and at the sprite rim
P 496 704 1 0 0  0 F F 0 0
P 560 704 1 0 0  F 8 0 0 0
P 656 704 1 0 0  F 0 F 0 0
P 720 704 1 0 0  0 0 0 0 0
P 545 704 1 0 0  7 4 0 0 0
P 496 96 1 0 0  F 0 F 0 0
P 528 96 1 0 0  0 0 0 0 0
# Ghost of a T piece at field row 18, column 3
P 592 608 1 0 0  5 5 5 0 0
P 577 608 1 0 0  2 2 2 0 0
P 592 640 1 0 0  0 0 0 0 0
P 624 640 1 0 0  5 5 5 0 0
# Preview box with an O piece
P 900 85 1 0 0  F F F 0 0
P 900 100 1 0 0  0 0 0 0 0
P 918 136 1 0 0  F F 0 0 0
P 902 136 1 0 0  7 7 0 0 0
P 880 136 1 0 0  0 0 0 0 0
# Game over
C 1 0027 3 18 0066 3
P 592 608 1 0 0  0 0 0 0 0
P 528 704 1 0 0  4 4 4 0 0
P 545 704 1 0 0  2 2 2 0 0
P 918 136 1 0 0  F F 0 0 0

// File: all.f
rtl/screen_pkg.sv
rtl/tetris_pkg.sv
rtl/render_if.sv
rtl/screen_region_decoder.sv
rtl/cell_lookup.sv
rtl/pixel_colorizer.sv
rtl/tetris_render_top.sv
verif/tb_tetris_render.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_tetris_render
FILELIST  = all.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
